// File: hw/div_pkg.sv
package div_pkg;

    // operand width; a result carries remainder and quotient side by side
    parameter int DATA_WIDTH = 32;

    // one shift-subtract step per operand bit plus one cycle for the sign fix
    parameter int LANE_CYCLES = DATA_WIDTH + 1;

    typedef enum logic {
        DIV_SIGNED   = 1'b0,
        DIV_UNSIGNED = 1'b1
    } div_op_e;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_RUN  = 2'd1,
        LANE_DONE = 2'd2
    } lane_state_e;

endpackage

// File: hw/div_dispatch.sv
`timescale 1ns/1ps

module div_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_valid,
    output logic                 in_ready,

    output logic [NUM_LANES-1:0] lane_valid,
    input  logic [NUM_LANES-1:0] lane_ready
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] wr_ptr;
    logic             in_fire;

    // a full lane under the pointer stalls the whole input port
    assign in_ready = lane_ready[wr_ptr];
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        lane_valid = '0;
        lane_valid[wr_ptr] = in_valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (in_fire) begin
            if (wr_ptr == LAST_LANE) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hw/div_lane.sv
`timescale 1ns/1ps

module div_lane import div_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    start_valid,
    output logic                    start_ready,
    input  div_op_e                 op,
    input  logic [DATA_WIDTH-1:0]   dividend,
    input  logic [DATA_WIDTH-1:0]   divisor,

    output logic                    res_valid,
    input  logic                    res_ready,
    output logic [2*DATA_WIDTH-1:0] res_data
);

    localparam int CNT_W = $clog2(LANE_CYCLES);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_WIDTH);

    lane_state_e             state;
    logic [CNT_W-1:0]        step_cnt;

    logic [DATA_WIDTH-1:0]   rem_q;
    logic [DATA_WIDTH-1:0]   quo_q;
    logic [DATA_WIDTH-1:0]   dvs_q;
    logic                    neg_quo;
    logic                    neg_rem;
    logic                    div_zero;
    logic [2*DATA_WIDTH-1:0] result_q;

    logic                    dividend_neg;
    logic                    divisor_neg;
    logic [DATA_WIDTH-1:0]   dividend_mag;
    logic [DATA_WIDTH-1:0]   divisor_mag;
    logic [DATA_WIDTH:0]     shifted;
    logic [DATA_WIDTH:0]     trial;
    logic [DATA_WIDTH-1:0]   quo_fix;
    logic [DATA_WIDTH-1:0]   rem_fix;
    logic                    start_fire;

    assign start_ready = (state == LANE_IDLE);
    assign res_valid   = (state == LANE_DONE);
    assign res_data    = result_q;
    assign start_fire  = start_valid && start_ready;

    // operand signs only count for signed divides
    assign dividend_neg = (op == DIV_SIGNED) && dividend[DATA_WIDTH-1];
    assign divisor_neg  = (op == DIV_SIGNED) && divisor[DATA_WIDTH-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // restoring step: bring in the next dividend bit and try the subtract
    assign shifted = {rem_q, quo_q[DATA_WIDTH-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    // divide by zero forces all ones; the remainder already equals the dividend
    assign quo_fix = div_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign rem_fix = neg_rem ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= LANE_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (start_valid) begin
                        state    <= LANE_RUN;
                        step_cnt <= '0;
                    end
                end
                LANE_RUN: begin
                    if (step_cnt == LAST_STEP) begin
                        state <= LANE_DONE;
                    end
                    step_cnt <= step_cnt + 1'b1;
                end
                LANE_DONE: begin
                    if (res_ready) begin
                        state <= LANE_IDLE;
                    end
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fire) begin
            rem_q    <= '0;
            quo_q    <= dividend_mag;
            dvs_q    <= divisor_mag;
            neg_quo  <= dividend_neg ^ divisor_neg;
            neg_rem  <= dividend_neg;
            div_zero <= (divisor == '0);
        end else if (state == LANE_RUN) begin
            if (step_cnt < LAST_STEP) begin
                if (!trial[DATA_WIDTH]) begin
                    rem_q <= trial[DATA_WIDTH-1:0];
                    quo_q <= {quo_q[DATA_WIDTH-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[DATA_WIDTH-1:0];
                    quo_q <= {quo_q[DATA_WIDTH-2:0], 1'b0};
                end
            end else begin
                // last cycle, HI holds the remainder and LO the quotient
                result_q <= {rem_fix, quo_fix};
            end
        end
    end

endmodule

// File: hw/div_collect.sv
`timescale 1ns/1ps

module div_collect import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [NUM_LANES-1:0]              res_valid,
    output logic [NUM_LANES-1:0]              res_ready,
    input  logic [NUM_LANES*2*DATA_WIDTH-1:0] res_data,

    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [2*DATA_WIDTH-1:0]           out_result
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int RES_W = 2 * DATA_WIDTH;
    localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] rd_ptr;
    logic             out_fire;

    // only the lane under the pointer may present its result
    assign out_valid  = res_valid[rd_ptr];
    assign out_result = res_data[rd_ptr*RES_W +: RES_W];
    assign out_fire   = out_valid && out_ready;

    always_comb begin
        res_ready = '0;
        res_ready[rd_ptr] = out_ready;
    end

    // follows the dispatch order, so results leave in request order
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (out_fire) begin
            if (rd_ptr == LAST_LANE) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hw/div_array.sv
`timescale 1ns/1ps

module div_array import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  div_op_e                 in_op,
    input  logic [DATA_WIDTH-1:0]   in_dividend,
    input  logic [DATA_WIDTH-1:0]   in_divisor,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [2*DATA_WIDTH-1:0] out_result
);

    logic [NUM_LANES-1:0]              lane_valid;
    logic [NUM_LANES-1:0]              lane_ready;
    logic [NUM_LANES-1:0]              res_valid;
    logic [NUM_LANES-1:0]              res_ready;
    logic [NUM_LANES*2*DATA_WIDTH-1:0] res_data;

    div_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

    // operands fan out to every lane, lane_valid picks the one that captures
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        div_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .start_valid (lane_valid[i]),
            .start_ready (lane_ready[i]),
            .op          (in_op),
            .dividend    (in_dividend),
            .divisor     (in_divisor),
            .res_valid   (res_valid[i]),
            .res_ready   (res_ready[i]),
            .res_data    (res_data[i*2*DATA_WIDTH +: 2*DATA_WIDTH])
        );
    end

    div_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

endmodule

// File: verification/div_array_properties.sv
`timescale 1ns/1ps

module div_array_properties import div_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    out_valid,
    input logic                    out_ready,
    input logic [2*DATA_WIDTH-1:0] out_result,
    input logic [NUM_LANES-1:0]    lane_valid,
    input logic                    lane0_start,
    input lane_state_e             lane0_state
);

    int stable_fails = 0;
    int reset_fails = 0;
    int latency_fails = 0;
    int fail_count;

    assign fail_count = stable_fails + reset_fails + latency_fails;

    // a stalled result must be held unchanged by its lane
    result_stable_while_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
        else begin
            $error("out_result changed or dropped while the output was stalled");
            stable_fails++;
        end

    no_lane_start_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (lane_valid == '0))
        else begin
            $error("a lane was started on the first cycle after reset");
            reset_fails++;
        end

    // state turns to LANE_DONE on the LANE_CYCLES-th edge after the start edge
    lane0_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        lane0_start |-> ##LANE_CYCLES (lane0_state == LANE_RUN) ##1 (lane0_state == LANE_DONE))
        else begin
            $error("lane 0 did not reach LANE_DONE after the fixed latency");
            latency_fails++;
        end

endmodule

bind div_array div_array_properties #(
    .NUM_LANES (NUM_LANES)
) u_props (
    .clk         (clk),
    .rst         (rst),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result),
    .lane_valid  (lane_valid),
    .lane0_start (gen_lane[0].u_lane.start_fire),
    .lane0_state (gen_lane[0].u_lane.state)
);

// File: verification/div_array_checker.sv
`timescale 1ns/1ps

module div_array_checker import div_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  div_op_e                 in_op,
    input  logic [DATA_WIDTH-1:0]   in_dividend,
    input  logic [DATA_WIDTH-1:0]   in_divisor,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic [2*DATA_WIDTH-1:0] out_result,
    input  int                      assert_errors,
    input  logic                    end_check,
    output int                      pending,
    output int                      error_total,
    output logic                    report_done
);

    logic [2*DATA_WIDTH-1:0] exp_q[$];
    longint                  accept_q[$];
    int                      stall_q[$];
    logic [2*DATA_WIDTH-1:0] expected;
    longint                  accept_cycle;
    longint                  cycle = 0;
    int                      stall_snap;
    int                      stall_count = 0;
    int                      latency;
    int                      exact_checks = 0;
    int                      input_stalls = 0;
    int                      mismatch_errors = 0;
    int                      other_errors = 0;
    logic                    rst_q = 1'b1;

    // truncating division, the remainder takes the sign of the dividend
    function automatic logic [2*DATA_WIDTH-1:0] expected_result(
        input div_op_e               op,
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        longint                sa;
        longint                sb;
        logic [DATA_WIDTH-1:0] quo;
        logic [DATA_WIDTH-1:0] rem;
        if (b == '0) begin
            quo = '1;
            rem = a;
        end else if (op == DIV_UNSIGNED) begin
            quo = a / b;
            rem = a % b;
        end else begin
            sa  = longint'($signed(a));
            sb  = longint'($signed(b));
            quo = DATA_WIDTH'(sa / sb);
            rem = DATA_WIDTH'(sa % sb);
        end
        return {rem, quo};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            pending     <= 0;
            error_total <= 0;
            report_done <= 1'b0;
        end else begin
            if (rst_q) begin
                if (out_valid !== 1'b0) begin
                    $display("mismatch out_valid after reset: expected %h actual %h",
                             1'b0, out_valid);
                    mismatch_errors++;
                end
                if (in_ready !== 1'b1) begin
                    $display("mismatch in_ready after reset: expected %h actual %h",
                             1'b1, in_ready);
                    mismatch_errors++;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_result(in_op, in_dividend, in_divisor));
                accept_q.push_back(cycle);
                stall_q.push_back(stall_count);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a result came out with no request outstanding");
                    other_errors++;
                end else begin
                    expected     = exp_q.pop_front();
                    accept_cycle = accept_q.pop_front();
                    stall_snap   = stall_q.pop_front();
                    if (out_result !== expected) begin
                        $display("mismatch out_result: expected %h actual %h",
                                 expected, out_result);
                        mismatch_errors++;
                    end
                    // valid rises LANE_CYCLES edges after the accept, the transfer one later
                    latency = int'(cycle - accept_cycle);
                    if (latency < LANE_CYCLES + 1) begin
                        $display("a result came out after %0d cycles, too early", latency);
                        other_errors++;
                    end else if (stall_snap == stall_count) begin
                        exact_checks++;
                        if (latency != LANE_CYCLES + 1) begin
                            $display("an unstalled result took %0d cycles instead of %0d",
                                     latency, LANE_CYCLES + 1);
                            other_errors++;
                        end
                    end
                end
            end
            if (in_valid && !in_ready) begin
                input_stalls++;
            end
            if (!out_ready) begin
                stall_count++;
            end
            pending <= exp_q.size();
            if (end_check && !report_done) begin
                if (exp_q.size() != 0) begin
                    $display("%0d requests never returned a result", exp_q.size());
                    other_errors++;
                end
                if (exact_checks == 0) begin
                    $display("no result was seen with the output free of stalls");
                    other_errors++;
                end
                if (input_stalls == 0) begin
                    $display("the input was never held off by full lanes");
                    other_errors++;
                end
                $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                         mismatch_errors, other_errors, assert_errors);
                error_total <= mismatch_errors + other_errors + assert_errors;
                report_done <= 1'b1;
            end
        end
        rst_q = rst;
        cycle++;
    end

endmodule

// File: verification/div_array_tb.sv
`timescale 1ns/1ps

module div_array_tb import div_pkg::*; ();

    localparam int NUM_REQUESTS = 200 + 200 + 10 + 100 + 8;
    localparam int WATCHDOG_NS  = NUM_REQUESTS * 200 + 2000;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    div_op_e                 in_op;
    logic [DATA_WIDTH-1:0]   in_dividend;
    logic [DATA_WIDTH-1:0]   in_divisor;
    logic                    out_valid;
    logic                    out_ready;
    logic [2*DATA_WIDTH-1:0] out_result;
    logic                    random_ready;
    logic                    end_check;
    int                      pending;
    int                      error_total;
    logic                    report_done;

    div_array #(
        .NUM_LANES (4)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_dividend (in_dividend),
        .in_divisor  (in_divisor),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

    div_array_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_dividend   (in_dividend),
        .in_divisor    (in_divisor),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .assert_errors (u_dut.u_props.fail_count),
        .end_check     (end_check),
        .pending       (pending),
        .error_total   (error_total),
        .report_done   (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // magnitudes spread over many sizes so quotients are not all tiny
    function automatic logic [DATA_WIDTH-1:0] random_operand(input logic allow_negative);
        logic [DATA_WIDTH-1:0] value;
        value = $urandom() >> $urandom_range(0, DATA_WIDTH - 1);
        if (allow_negative && ($urandom_range(0, 1) == 1)) begin
            value = -value;
        end
        return value;
    endfunction

    task automatic send_request(input div_op_e op, input logic [DATA_WIDTH-1:0] a,
                                input logic [DATA_WIDTH-1:0] b);
        in_valid    <= 1'b1;
        in_op       <= op;
        in_dividend <= a;
        in_divisor  <= b;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (pending != 0) begin
            @(posedge clk);
        end
    endtask

    // out_ready phases: every third one is a long stall, the others toggle randomly
    initial begin : ready_driver
        int   phase_left;
        int   phase_num;
        logic hold_low;
        out_ready  = 1'b1;
        phase_left = 0;
        phase_num  = 0;
        hold_low   = 1'b0;
        forever begin
            @(posedge clk);
            if (!random_ready) begin
                out_ready <= 1'b1;
            end else begin
                if (phase_left == 0) begin
                    hold_low   = (phase_num % 3 == 0);
                    phase_left = hold_low ? 100 : int'($urandom_range(10, 40));
                    phase_num++;
                end
                phase_left--;
                if (hold_low) begin
                    out_ready <= 1'b0;
                end else begin
                    out_ready <= ($urandom_range(0, 1) == 1);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(71601));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_op        = DIV_UNSIGNED;
        in_dividend  = '0;
        in_divisor   = '0;
        random_ready = 1'b0;
        end_check    = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < 200; i++) begin
            send_request(DIV_UNSIGNED, random_operand(1'b0), random_operand(1'b0));
        end

        send_request(DIV_SIGNED, 32'h8000_0000, 32'hFFFF_FFFF);
        send_request(DIV_SIGNED, 32'hFFFF_FFF9, 32'd2);
        send_request(DIV_SIGNED, 32'd7, 32'hFFFF_FFFE);
        send_request(DIV_SIGNED, 32'hFFFF_FFF9, 32'hFFFF_FFFE);
        send_request(DIV_SIGNED, 32'h8000_0000, 32'd1);
        for (int i = 0; i < 195; i++) begin
            send_request(DIV_SIGNED, random_operand(1'b1), random_operand(1'b1));
        end

        send_request(DIV_SIGNED, 32'd0, 32'd0);
        send_request(DIV_SIGNED, 32'd1, 32'd0);
        send_request(DIV_SIGNED, 32'h8000_0000, 32'd0);
        send_request(DIV_SIGNED, 32'hFFFF_FFFF, 32'd0);
        send_request(DIV_SIGNED, 32'h1234_5678, 32'd0);
        send_request(DIV_UNSIGNED, 32'd0, 32'd0);
        send_request(DIV_UNSIGNED, 32'd1, 32'd0);
        send_request(DIV_UNSIGNED, 32'h8000_0000, 32'd0);
        send_request(DIV_UNSIGNED, 32'hFFFF_FFFF, 32'd0);
        send_request(DIV_UNSIGNED, 32'h1234_5678, 32'd0);
        wait_drain();

        random_ready <= 1'b1;
        for (int i = 0; i < 100; i++) begin
            send_request(($urandom_range(0, 1) == 1) ? DIV_SIGNED : DIV_UNSIGNED,
                         random_operand(1'b1), random_operand(1'b1));
        end
        wait_drain();
        random_ready <= 1'b0;

        // back to back with the output free, checked against the fixed latency
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            send_request(DIV_UNSIGNED, random_operand(1'b0), random_operand(1'b0));
        end
        wait_drain();

        end_check <= 1'b1;
        while (report_done !== 1'b1) begin
            @(posedge clk);
        end
        if (error_total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: div_array.f
hw/div_pkg.sv
hw/div_dispatch.sv
hw/div_lane.sv
hw/div_collect.sv
hw/div_array.sv
verification/div_array_properties.sv
verification/div_array_checker.sv
verification/div_array_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module div_array_tb -f div_array.f -Mdir obj_dir -o div_array_sim

run: compile
	./obj_dir/div_array_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
